/* logic/mcore_mem_cfg.svh */
/* Widths and sizes of the shared tagged word memory.
   Included by the package and by any RTL that sizes its own storage. */

`ifndef MCORE_MEM_CFG_SVH
`define MCORE_MEM_CFG_SVH

// word address and data widths
`define MCORE_MEM_ADDR_NBITS 8
`define MCORE_MEM_DATA_NBITS 32

// memory depth in words, one word per address
`define MCORE_MEM_NWORDS 256

// request ports sharing the memory
// the arbiter is built for two
`define MCORE_MEM_NUM_PORTS 2

`endif

/* logic/mcore_mem_pkg.sv */
/* Shared types of the two-port tagged memory: request kind, security
   domain, address, data and the port id carried as the opaque field. */

`include "mcore_mem_cfg.svh"

package mcore_mem_pkg;

	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_type_t;

	// tag kept with every word, and the domain of each request
	typedef enum logic {
		DOM_PUBLIC = 1'b0,
		DOM_SECURE = 1'b1
	} domain_t;

	typedef logic [`MCORE_MEM_ADDR_NBITS-1:0] addr_t;
	typedef logic [`MCORE_MEM_DATA_NBITS-1:0] data_t;

	// routes a memory response back to its port
	typedef logic [$clog2(`MCORE_MEM_NUM_PORTS)-1:0] port_id_t;

endpackage

/* logic/port_frontend.sv */
/* Front-end of one request port. Buffers an accepted request until the
   arbiter grants it, tracks it in flight and holds the response until taken. */

module port_frontend (
	input  logic                      clk,
	input  logic                      arst_n,

	// external request
	input  logic                      req_val,
	output logic                      req_rdy,
	input  mcore_mem_pkg::mem_type_t  req_type,
	input  mcore_mem_pkg::addr_t      req_addr,
	input  mcore_mem_pkg::data_t      req_data,
	input  mcore_mem_pkg::domain_t    req_domain,

	// external response
	output logic                      resp_val,
	input  logic                      resp_rdy,
	output mcore_mem_pkg::mem_type_t  resp_type,
	output mcore_mem_pkg::data_t      resp_data,
	output logic                      resp_denied,

	// toward the arbiter
	output logic                      mem_req_val,
	output mcore_mem_pkg::mem_type_t  mem_req_type,
	output mcore_mem_pkg::addr_t      mem_req_addr,
	output mcore_mem_pkg::data_t      mem_req_data,
	output mcore_mem_pkg::domain_t    mem_req_domain,
	input  logic                      mem_req_gnt,

	// response pulse steered back by the arbiter
	input  logic                      mem_resp_val,
	input  mcore_mem_pkg::mem_type_t  mem_resp_type,
	input  mcore_mem_pkg::data_t      mem_resp_data,
	input  logic                      mem_resp_denied
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_GNT,
		ST_WAIT_RESP
	} fe_state_t;

	fe_state_t state;
	fe_state_t state_next;
	logic      req_fire;
	logic      gnt_fire;
	logic      resp_capture;
	logic      resp_fire;

	// one request at a time, and only once the last response is gone
	assign req_rdy      = (state == ST_IDLE) && !resp_val;
	assign mem_req_val  = (state == ST_WAIT_GNT);

	assign req_fire     = req_val && req_rdy;
	assign gnt_fire     = mem_req_val && mem_req_gnt;
	assign resp_capture = mem_resp_val && (state == ST_WAIT_RESP);
	assign resp_fire    = resp_val && resp_rdy;

	//==========================================================
	// FSM
	//==========================================================

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (req_fire) begin
					state_next = ST_WAIT_GNT;
				end
			end
			ST_WAIT_GNT: begin
				if (gnt_fire) begin
					state_next = ST_WAIT_RESP;
				end
			end
			ST_WAIT_RESP: begin
				if (resp_capture) begin
					state_next = ST_IDLE;
				end
			end
			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	//==========================================================
	// request buffer and response register
	//==========================================================

	always_ff @(posedge clk) begin
		if (req_fire) begin
			mem_req_type   <= req_type;
			mem_req_addr   <= req_addr;
			mem_req_data   <= req_data;
			mem_req_domain <= req_domain;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			resp_val <= 1'b0;
		end else if (resp_capture) begin
			resp_val <= 1'b1;
		end else if (resp_fire) begin
			resp_val <= 1'b0;
		end
	end

	// held stable while the port back-pressures
	always_ff @(posedge clk) begin
		if (resp_capture) begin
			resp_type   <= mem_resp_type;
			resp_data   <= mem_resp_data;
			resp_denied <= mem_resp_denied;
		end
	end

endmodule

/* logic/mem_arbiter.sv */
/* Round-robin arbiter of the two port front-ends onto the tagged memory.
   Tags each request with its port id and routes the response pulse back. */

module mem_arbiter (
	input  logic                      clk,
	input  logic                      arst_n,

	// port a (port 0)
	input  logic                      a_mem_req_val,
	input  mcore_mem_pkg::mem_type_t  a_mem_req_type,
	input  mcore_mem_pkg::addr_t      a_mem_req_addr,
	input  mcore_mem_pkg::data_t      a_mem_req_data,
	input  mcore_mem_pkg::domain_t    a_mem_req_domain,
	output logic                      a_mem_req_gnt,
	output logic                      a_mem_resp_val,
	output mcore_mem_pkg::mem_type_t  a_mem_resp_type,
	output mcore_mem_pkg::data_t      a_mem_resp_data,
	output logic                      a_mem_resp_denied,

	// port b (port 1)
	input  logic                      b_mem_req_val,
	input  mcore_mem_pkg::mem_type_t  b_mem_req_type,
	input  mcore_mem_pkg::addr_t      b_mem_req_addr,
	input  mcore_mem_pkg::data_t      b_mem_req_data,
	input  mcore_mem_pkg::domain_t    b_mem_req_domain,
	output logic                      b_mem_req_gnt,
	output logic                      b_mem_resp_val,
	output mcore_mem_pkg::mem_type_t  b_mem_resp_type,
	output mcore_mem_pkg::data_t      b_mem_resp_data,
	output logic                      b_mem_resp_denied,

	// to memory
	output logic                      mreq_val,
	output mcore_mem_pkg::mem_type_t  mreq_type,
	output mcore_mem_pkg::addr_t      mreq_addr,
	output mcore_mem_pkg::data_t      mreq_data,
	output mcore_mem_pkg::domain_t    mreq_domain,
	output mcore_mem_pkg::port_id_t   mreq_id,

	// from memory
	input  logic                      mresp_val,
	input  mcore_mem_pkg::mem_type_t  mresp_type,
	input  mcore_mem_pkg::data_t      mresp_data,
	input  logic                      mresp_denied,
	input  mcore_mem_pkg::port_id_t   mresp_id
);

	import mcore_mem_pkg::*;

	port_id_t last_gnt;

	//==========================================================
	// grant
	//==========================================================

	// b wins a conflict when a was served last
	assign b_mem_req_gnt = b_mem_req_val && (!a_mem_req_val || last_gnt == port_id_t'(0));
	assign a_mem_req_gnt = a_mem_req_val && !b_mem_req_gnt;

	// port 0 counts as last granted out of reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			last_gnt <= port_id_t'(0);
		end else if (a_mem_req_gnt) begin
			last_gnt <= port_id_t'(0);
		end else if (b_mem_req_gnt) begin
			last_gnt <= port_id_t'(1);
		end
	end

	always_comb begin
		mreq_val = a_mem_req_val || b_mem_req_val;
		if (b_mem_req_gnt) begin
			mreq_type   = b_mem_req_type;
			mreq_addr   = b_mem_req_addr;
			mreq_data   = b_mem_req_data;
			mreq_domain = b_mem_req_domain;
			mreq_id     = port_id_t'(1);
		end else begin
			mreq_type   = a_mem_req_type;
			mreq_addr   = a_mem_req_addr;
			mreq_data   = a_mem_req_data;
			mreq_domain = a_mem_req_domain;
			mreq_id     = port_id_t'(0);
		end
	end

	//==========================================================
	// response routing
	//==========================================================

	// fields go to both ports and only the valid is steered
	assign a_mem_resp_val    = mresp_val && (mresp_id == port_id_t'(0));
	assign a_mem_resp_type   = mresp_type;
	assign a_mem_resp_data   = mresp_data;
	assign a_mem_resp_denied = mresp_denied;

	assign b_mem_resp_val    = mresp_val && (mresp_id == port_id_t'(1));
	assign b_mem_resp_type   = mresp_type;
	assign b_mem_resp_data   = mresp_data;
	assign b_mem_resp_denied = mresp_denied;

endmodule

/* logic/tagged_mem.sv */
/* Word memory with a public/secure tag per word. Checks every access
   against the tag and answers with a one-cycle pulse carrying the port id. */

`include "mcore_mem_cfg.svh"

module tagged_mem (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      mem_clear,

	// request, accepted every cycle
	input  logic                      mreq_val,
	input  mcore_mem_pkg::mem_type_t  mreq_type,
	input  mcore_mem_pkg::addr_t      mreq_addr,
	input  mcore_mem_pkg::data_t      mreq_data,
	input  mcore_mem_pkg::domain_t    mreq_domain,
	input  mcore_mem_pkg::port_id_t   mreq_id,

	// response pulse
	output logic                      mresp_val,
	output mcore_mem_pkg::mem_type_t  mresp_type,
	output mcore_mem_pkg::data_t      mresp_data,
	output logic                      mresp_denied,
	output mcore_mem_pkg::port_id_t   mresp_id
);

	import mcore_mem_pkg::*;

	data_t   mem_data [`MCORE_MEM_NWORDS];
	domain_t mem_tag  [`MCORE_MEM_NWORDS];

	data_t   rd_word;
	domain_t rd_tag;
	logic    denied;
	logic    wr_en;

	assign rd_word = mem_data[mreq_addr];
	assign rd_tag  = mem_tag[mreq_addr];

	// public requests may neither read nor write secure words
	assign denied = (mreq_domain == DOM_PUBLIC) && (rd_tag == DOM_SECURE);
	assign wr_en  = mreq_val && (mreq_type == MEM_WRITE) && !denied;

	//==========================================================
	// storage
	//==========================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `MCORE_MEM_NWORDS; i++) begin
				mem_data[i] <= '0;
				mem_tag[i]  <= DOM_PUBLIC;
			end
		end else if (mem_clear) begin
			for (int i = 0; i < `MCORE_MEM_NWORDS; i++) begin
				mem_data[i] <= '0;
				mem_tag[i]  <= DOM_PUBLIC;
			end
		end else if (wr_en) begin
			// the writer's domain becomes the word's tag
			mem_data[mreq_addr] <= mreq_data;
			mem_tag[mreq_addr]  <= mreq_domain;
		end
	end

	//==========================================================
	// response
	//==========================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mresp_val <= 1'b0;
		end else begin
			mresp_val <= mreq_val;
		end
	end

	// write and denied responses return zero data
	always_ff @(posedge clk) begin
		if (mreq_val) begin
			mresp_type   <= mreq_type;
			mresp_id     <= mreq_id;
			mresp_denied <= denied;
			if ((mreq_type == MEM_READ) && !denied) begin
				mresp_data <= rd_word;
			end else begin
				mresp_data <= '0;
			end
		end
	end

endmodule

/* logic/mcore_mem_top.sv */
/* Two-port shared memory with security domains. Two port front-ends
   share one tagged memory through a round-robin arbiter. */

module mcore_mem_top (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      mem_clear,

	// port 0
	input  logic                      p0_req_val,
	output logic                      p0_req_rdy,
	input  mcore_mem_pkg::mem_type_t  p0_req_type,
	input  mcore_mem_pkg::addr_t      p0_req_addr,
	input  mcore_mem_pkg::data_t      p0_req_data,
	input  mcore_mem_pkg::domain_t    p0_req_domain,
	output logic                      p0_resp_val,
	input  logic                      p0_resp_rdy,
	output mcore_mem_pkg::mem_type_t  p0_resp_type,
	output mcore_mem_pkg::data_t      p0_resp_data,
	output logic                      p0_resp_denied,

	// port 1
	input  logic                      p1_req_val,
	output logic                      p1_req_rdy,
	input  mcore_mem_pkg::mem_type_t  p1_req_type,
	input  mcore_mem_pkg::addr_t      p1_req_addr,
	input  mcore_mem_pkg::data_t      p1_req_data,
	input  mcore_mem_pkg::domain_t    p1_req_domain,
	output logic                      p1_resp_val,
	input  logic                      p1_resp_rdy,
	output mcore_mem_pkg::mem_type_t  p1_resp_type,
	output mcore_mem_pkg::data_t      p1_resp_data,
	output logic                      p1_resp_denied
);

	import mcore_mem_pkg::*;

	// front-end 0 to arbiter
	logic      p0_mem_req_val;
	mem_type_t p0_mem_req_type;
	addr_t     p0_mem_req_addr;
	data_t     p0_mem_req_data;
	domain_t   p0_mem_req_domain;
	logic      p0_mem_req_gnt;
	logic      p0_mem_resp_val;
	mem_type_t p0_mem_resp_type;
	data_t     p0_mem_resp_data;
	logic      p0_mem_resp_denied;

	// front-end 1 to arbiter
	logic      p1_mem_req_val;
	mem_type_t p1_mem_req_type;
	addr_t     p1_mem_req_addr;
	data_t     p1_mem_req_data;
	domain_t   p1_mem_req_domain;
	logic      p1_mem_req_gnt;
	logic      p1_mem_resp_val;
	mem_type_t p1_mem_resp_type;
	data_t     p1_mem_resp_data;
	logic      p1_mem_resp_denied;

	// arbiter and memory
	logic      mreq_val;
	mem_type_t mreq_type;
	addr_t     mreq_addr;
	data_t     mreq_data;
	domain_t   mreq_domain;
	port_id_t  mreq_id;
	logic      mresp_val;
	mem_type_t mresp_type;
	data_t     mresp_data;
	logic      mresp_denied;
	port_id_t  mresp_id;

	//==========================================================
	// port front-ends
	//==========================================================

	port_frontend i_port0 (
		.clk             (clk),
		.arst_n          (arst_n),
		.req_val         (p0_req_val),
		.req_rdy         (p0_req_rdy),
		.req_type        (p0_req_type),
		.req_addr        (p0_req_addr),
		.req_data        (p0_req_data),
		.req_domain      (p0_req_domain),
		.resp_val        (p0_resp_val),
		.resp_rdy        (p0_resp_rdy),
		.resp_type       (p0_resp_type),
		.resp_data       (p0_resp_data),
		.resp_denied     (p0_resp_denied),
		.mem_req_val     (p0_mem_req_val),
		.mem_req_type    (p0_mem_req_type),
		.mem_req_addr    (p0_mem_req_addr),
		.mem_req_data    (p0_mem_req_data),
		.mem_req_domain  (p0_mem_req_domain),
		.mem_req_gnt     (p0_mem_req_gnt),
		.mem_resp_val    (p0_mem_resp_val),
		.mem_resp_type   (p0_mem_resp_type),
		.mem_resp_data   (p0_mem_resp_data),
		.mem_resp_denied (p0_mem_resp_denied)
	);

	port_frontend i_port1 (
		.clk             (clk),
		.arst_n          (arst_n),
		.req_val         (p1_req_val),
		.req_rdy         (p1_req_rdy),
		.req_type        (p1_req_type),
		.req_addr        (p1_req_addr),
		.req_data        (p1_req_data),
		.req_domain      (p1_req_domain),
		.resp_val        (p1_resp_val),
		.resp_rdy        (p1_resp_rdy),
		.resp_type       (p1_resp_type),
		.resp_data       (p1_resp_data),
		.resp_denied     (p1_resp_denied),
		.mem_req_val     (p1_mem_req_val),
		.mem_req_type    (p1_mem_req_type),
		.mem_req_addr    (p1_mem_req_addr),
		.mem_req_data    (p1_mem_req_data),
		.mem_req_domain  (p1_mem_req_domain),
		.mem_req_gnt     (p1_mem_req_gnt),
		.mem_resp_val    (p1_mem_resp_val),
		.mem_resp_type   (p1_mem_resp_type),
		.mem_resp_data   (p1_mem_resp_data),
		.mem_resp_denied (p1_mem_resp_denied)
	);

	//==========================================================
	// arbiter and shared memory
	//==========================================================

	mem_arbiter i_arb (
		.clk               (clk),
		.arst_n            (arst_n),
		.a_mem_req_val     (p0_mem_req_val),
		.a_mem_req_type    (p0_mem_req_type),
		.a_mem_req_addr    (p0_mem_req_addr),
		.a_mem_req_data    (p0_mem_req_data),
		.a_mem_req_domain  (p0_mem_req_domain),
		.a_mem_req_gnt     (p0_mem_req_gnt),
		.a_mem_resp_val    (p0_mem_resp_val),
		.a_mem_resp_type   (p0_mem_resp_type),
		.a_mem_resp_data   (p0_mem_resp_data),
		.a_mem_resp_denied (p0_mem_resp_denied),
		.b_mem_req_val     (p1_mem_req_val),
		.b_mem_req_type    (p1_mem_req_type),
		.b_mem_req_addr    (p1_mem_req_addr),
		.b_mem_req_data    (p1_mem_req_data),
		.b_mem_req_domain  (p1_mem_req_domain),
		.b_mem_req_gnt     (p1_mem_req_gnt),
		.b_mem_resp_val    (p1_mem_resp_val),
		.b_mem_resp_type   (p1_mem_resp_type),
		.b_mem_resp_data   (p1_mem_resp_data),
		.b_mem_resp_denied (p1_mem_resp_denied),
		.mreq_val          (mreq_val),
		.mreq_type         (mreq_type),
		.mreq_addr         (mreq_addr),
		.mreq_data         (mreq_data),
		.mreq_domain       (mreq_domain),
		.mreq_id           (mreq_id),
		.mresp_val         (mresp_val),
		.mresp_type        (mresp_type),
		.mresp_data        (mresp_data),
		.mresp_denied      (mresp_denied),
		.mresp_id          (mresp_id)
	);

	tagged_mem i_mem (
		.clk          (clk),
		.arst_n       (arst_n),
		.mem_clear    (mem_clear),
		.mreq_val     (mreq_val),
		.mreq_type    (mreq_type),
		.mreq_addr    (mreq_addr),
		.mreq_data    (mreq_data),
		.mreq_domain  (mreq_domain),
		.mreq_id      (mreq_id),
		.mresp_val    (mresp_val),
		.mresp_type   (mresp_type),
		.mresp_data   (mresp_data),
		.mresp_denied (mresp_denied),
		.mresp_id     (mresp_id)
	);

endmodule

/* sim/mcore_mem_ref.svh */
/* Reference model of the tagged memory and the compare tasks of the testbench.
   Included inside the testbench module, after the package import. */

`ifndef MCORE_MEM_REF_SVH
`define MCORE_MEM_REF_SVH

typedef struct packed {
	mem_type_t kind;
	data_t     data;
	logic      denied;
} exp_resp_t;

data_t   model_data [`MCORE_MEM_NWORDS];
domain_t model_tag  [`MCORE_MEM_NWORDS];
int      error_count = 0;

// applies one access to the model and gives the expected answer
function automatic exp_resp_t expected_response(input mem_type_t kind, input addr_t addr,
		input data_t data, input domain_t dom);
	exp_resp_t resp;
	logic      blocked;
	// public may neither see nor overwrite a secure word
	blocked     = (dom == DOM_PUBLIC) && (model_tag[addr] == DOM_SECURE);
	resp.kind   = kind;
	resp.denied = blocked;
	resp.data   = '0;
	if (!blocked) begin
		if (kind == MEM_READ) begin
			resp.data = model_data[addr];
		end else begin
			model_data[addr] = data;
			model_tag[addr]  = dom;
		end
	end
	return resp;
endfunction

function automatic void clear_model();
	for (int i = 0; i < `MCORE_MEM_NWORDS; i++) begin
		model_data[i] = '0;
		model_tag[i]  = DOM_PUBLIC;
	end
endfunction

task automatic check_data(input data_t got, input data_t exp, input string what);
	if (got !== exp) begin
		error_count++;
		$display("[FAIL] t=%0t %s: data 0x%08h, expected 0x%08h", $time, what, got, exp);
	end
endtask

task automatic check_denied(input logic got, input logic exp, input string what);
	if (got !== exp) begin
		error_count++;
		$display("[FAIL] t=%0t %s: denied %0b, expected %0b", $time, what, got, exp);
	end
endtask

task automatic check_type(input mem_type_t got, input mem_type_t exp, input string what);
	if (got !== exp) begin
		error_count++;
		$display("[FAIL] t=%0t %s: type %s, expected %s", $time, what, got.name(), exp.name());
	end
endtask

`endif

/* sim/mcore_mem_tb.sv */
/* Testbench of the two-port tagged memory. Runs six directed and random
   tests against a reference model and prints a summary line at the end. */

`include "mcore_mem_cfg.svh"

module mcore_mem_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import mcore_mem_pkg::*;

	`include "mcore_mem_ref.svh"

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 5;
	localparam int NPORTS       = `MCORE_MEM_NUM_PORTS;
	localparam int T1_PAIRS     = 3;
	localparam int BURST_LEN    = 12;
	localparam int HOLD_CYCLES  = 20;
	// requests issued over all six tests
	localparam int NUM_TXNS = NPORTS * 2 * T1_PAIRS * 2 + 4 + 3 + NPORTS * BURST_LEN + 6 + 8;

	logic      clk = 1'b0;
	logic      arst_n;
	logic      mem_clear;
	logic      p0_req_val, p0_req_rdy, p0_resp_val, p0_resp_rdy, p0_resp_denied;
	logic      p1_req_val, p1_req_rdy, p1_resp_val, p1_resp_rdy, p1_resp_denied;
	mem_type_t p0_req_type, p0_resp_type, p1_req_type, p1_resp_type;
	addr_t     p0_req_addr, p1_req_addr;
	data_t     p0_req_data, p0_resp_data, p1_req_data, p1_resp_data;
	domain_t   p0_req_domain, p1_req_domain;

	exp_resp_t exp_q0 [$];
	exp_resp_t exp_q1 [$];
	int        resp_count [NPORTS] = '{default: 0};
	int        finish_cycle [NPORTS] = '{default: 0};
	int        txn_count = 0;
	int        test_count = 0;
	int        cycle_count = 0;
	integer    seed = 32'he983ad9d;

	mem_type_t burst_kind [NPORTS][BURST_LEN];
	addr_t     burst_addr [NPORTS][BURST_LEN];
	data_t     burst_data [NPORTS][BURST_LEN];
	domain_t   burst_dom  [NPORTS][BURST_LEN];

	mcore_mem_top i_dut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	//==========================================================
	// port driving and response checking
	//==========================================================

	task automatic drive_req(input int port, input logic val, input mem_type_t kind,
			input addr_t addr, input data_t data, input domain_t dom);
		if (port == 0) begin
			p0_req_val    = val;
			p0_req_type   = kind;
			p0_req_addr   = addr;
			p0_req_data   = data;
			p0_req_domain = dom;
		end else begin
			p1_req_val    = val;
			p1_req_type   = kind;
			p1_req_addr   = addr;
			p1_req_data   = data;
			p1_req_domain = dom;
		end
	endtask

	function automatic int pending(input int port);
		return (port == 0) ? exp_q0.size() : exp_q1.size();
	endfunction

	// starts and returns just after a rising edge
	task automatic send_req(input int port, input mem_type_t kind, input addr_t addr,
			input data_t data, input domain_t dom);
		logic accepted;
		accepted = 1'b0;
		drive_req(port, 1'b1, kind, addr, data, dom);
		while (!accepted) begin
			@(negedge clk);
			accepted = (port == 0) ? p0_req_rdy : p1_req_rdy;
		end
		if (port == 0) begin
			exp_q0.push_back(expected_response(kind, addr, data, dom));
		end else begin
			exp_q1.push_back(expected_response(kind, addr, data, dom));
		end
		txn_count++;
		@(posedge clk);
		#1;
		drive_req(port, 1'b0, kind, addr, data, dom);
	endtask

	task automatic wait_idle(input int port);
		do begin
			@(posedge clk);
		end while (pending(port) != 0);
		#1;
	endtask

	task automatic do_access(input int port, input mem_type_t kind, input addr_t addr,
			input data_t data, input domain_t dom);
		send_req(port, kind, addr, data, dom);
		wait_idle(port);
	endtask

	task automatic run_burst(input int port);
		for (int i = 0; i < BURST_LEN; i++) begin
			send_req(port, burst_kind[port][i], burst_addr[port][i], burst_data[port][i],
				burst_dom[port][i]);
		end
		wait_idle(port);
		finish_cycle[port] = cycle_count;
	endtask

	task automatic take_response(input int port, input mem_type_t kind, input data_t data,
			input logic denied);
		exp_resp_t want;
		string     what;
		what = $sformatf("port %0d response", port);
		if (pending(port) == 0) begin
			error_count++;
			$display("port %0d returned a response with no request outstanding", port);
		end else begin
			if (port == 0) begin
				want = exp_q0.pop_front();
			end else begin
				want = exp_q1.pop_front();
			end
			check_type(kind, want.kind, what);
			check_data(data, want.data, what);
			check_denied(denied, want.denied, what);
			resp_count[port]++;
		end
	endtask

	// sampled mid-cycle before the transfer edge
	task automatic compare_responses();
		forever begin
			@(negedge clk);
			if (arst_n && p0_resp_val && p0_resp_rdy) begin
				take_response(0, p0_resp_type, p0_resp_data, p0_resp_denied);
			end
			if (arst_n && p1_resp_val && p1_resp_rdy) begin
				take_response(1, p1_resp_type, p1_resp_data, p1_resp_denied);
			end
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		test_count++;
		$display("test %0d %s: %s, %0d mismatches", test_count, name,
			(error_count == errs_before) ? "pass" : "fail", error_count - errs_before);
	endtask

	//==========================================================
	// tests
	//==========================================================

	initial begin
		int          errs;
		int          release_cycle;
		int          p1_done_cycle;
		logic [31:0] rnd;
		addr_t       addr;
		domain_t     dom;
		arst_n      = 1'b0;
		mem_clear   = 1'b0;
		p0_resp_rdy = 1'b1;
		p1_resp_rdy = 1'b1;
		drive_req(0, 1'b0, MEM_READ, '0, '0, DOM_PUBLIC);
		drive_req(1, 1'b0, MEM_READ, '0, '0, DOM_PUBLIC);
		clear_model();
		fork
			compare_responses();
		join_none
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(negedge clk);
		if (!p0_req_rdy || !p1_req_rdy || p0_resp_val || p1_resp_val) begin
			error_count++;
			$display("ports are not idle and ready after reset");
		end
		@(posedge clk);
		#1;

		// public words in the low half and secure ones in the high half
		errs = error_count;
		for (int p = 0; p < NPORTS; p++) begin
			for (int d = 0; d < 2; d++) begin
				for (int i = 0; i < T1_PAIRS; i++) begin
					rnd  = $random(seed);
					dom  = (d == 0) ? DOM_PUBLIC : DOM_SECURE;
					addr = {d[0], rnd[6:0]};
					do_access(p, MEM_WRITE, addr, $random(seed), dom);
					do_access(p, MEM_READ, addr, '0, dom);
				end
			end
		end
		end_test("write and read back", errs);

		errs = error_count;
		do_access(0, MEM_WRITE, 8'h05, 32'h5ec0_0005, DOM_SECURE);
		do_access(1, MEM_READ, 8'h05, '0, DOM_PUBLIC);
		do_access(1, MEM_WRITE, 8'h06, 32'h0b11_0006, DOM_PUBLIC);
		do_access(0, MEM_READ, 8'h06, '0, DOM_SECURE);
		end_test("read domain rules", errs);

		errs = error_count;
		do_access(0, MEM_WRITE, 8'h07, 32'h5ec0_0007, DOM_SECURE);
		do_access(1, MEM_WRITE, 8'h07, 32'hbad0_0007, DOM_PUBLIC);
		do_access(0, MEM_READ, 8'h07, '0, DOM_SECURE);
		end_test("public write to secure word", errs);

		// even addresses on port 0 and odd ones on port 1
		errs = error_count;
		for (int p = 0; p < NPORTS; p++) begin
			for (int i = 0; i < BURST_LEN; i++) begin
				rnd = $random(seed);
				burst_kind[p][i] = rnd[0] ? MEM_WRITE : MEM_READ;
				burst_dom[p][i]  = rnd[1] ? DOM_SECURE : DOM_PUBLIC;
				burst_addr[p][i] = {rnd[15:9], p[0]};
				burst_data[p][i] = $random(seed);
			end
		end
		fork
			run_burst(0);
			run_burst(1);
		join
		if (finish_cycle[0] - finish_cycle[1] > 8 || finish_cycle[1] - finish_cycle[0] > 8) begin
			error_count++;
			$display("one port fell behind in the burst: port 0 done at cycle %0d, port 1 at %0d",
				finish_cycle[0], finish_cycle[1]);
		end
		end_test("concurrent bursts", errs);

		// secure access so the held word is the written data
		errs = error_count;
		do_access(0, MEM_WRITE, 8'h10, $random(seed), DOM_SECURE);
		p0_resp_rdy = 1'b0;
		fork
			begin
				send_req(0, MEM_READ, 8'h10, '0, DOM_SECURE);
				while (!p0_resp_val) @(negedge clk);
				repeat (HOLD_CYCLES) begin
					@(negedge clk);
					if (!p0_resp_val || p0_req_rdy) begin
						error_count++;
						$display("port 0 dropped its response or became ready under back-pressure");
					end
					check_data(p0_resp_data, exp_q0[0].data, "held port 0 response");
				end
				@(posedge clk);
				#1;
				release_cycle = cycle_count;
				p0_resp_rdy = 1'b1;
				wait_idle(0);
			end
			begin
				do_access(1, MEM_WRITE, 8'h11, 32'h1111_0011, DOM_SECURE);
				do_access(1, MEM_READ, 8'h11, '0, DOM_SECURE);
				do_access(1, MEM_WRITE, 8'h13, 32'h1313_0013, DOM_PUBLIC);
				do_access(1, MEM_READ, 8'h13, '0, DOM_PUBLIC);
				p1_done_cycle = cycle_count;
			end
		join
		if (p1_done_cycle >= release_cycle) begin
			error_count++;
			$display("port 1 stalled while port 0 was back-pressured");
		end
		end_test("response back-pressure", errs);

		errs = error_count;
		for (int i = 0; i < 4; i++) begin
			do_access(i % 2, MEM_WRITE, addr_t'(8'h20 + i), $random(seed),
				(i < 2) ? DOM_SECURE : DOM_PUBLIC);
		end
		mem_clear = 1'b1;
		@(posedge clk);
		#1;
		mem_clear = 1'b0;
		clear_model();
		for (int i = 0; i < 4; i++) begin
			do_access(1 - i % 2, MEM_READ, addr_t'(8'h20 + i), '0, DOM_PUBLIC);
		end
		end_test("memory clear", errs);

		$display("summary: %0d tests, %0d requests, %0d responses, %0d errors", test_count,
			txn_count, resp_count[0] + resp_count[1], error_count);
		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// 200 cycles per request plus margin
	initial begin
		#(CLK_PERIOD * (RESET_CYCLES + 200 * NUM_TXNS + 100));
		$display("timeout: the tests did not finish, a request or response never completed");
		$display("Errors found");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+logic
+incdir+sim
logic/mcore_mem_pkg.sv
logic/port_frontend.sv
logic/mem_arbiter.sv
logic/tagged_mem.sv
logic/mcore_mem_top.sv
sim/mcore_mem_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and pass only if the pass line shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module mcore_mem_tb -f vlog.f \
	|| { echo "build failed"; exit 1; }

out=$(./obj_dir/Vmcore_mem_tb)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "No errors" && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
